// ==== vlog.f ====
+incdir+common
common/cpuTrainerPkg.sv
common/progBusIf.sv
verilog/keyDebounce.sv
verilog/trainerControl.sv
cpu/progMem.sv
cpu/accCpu.sv
verilog/segDisplay.sv
verilog/cpuTrainerTop.sv
dv/trainerClockGen.sv
dv/cpuTrainer_checker.sv
dv/cpuTrainerTb.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --assert --timescale 1ns/1ps --top-module cpuTrainerTb -f vlog.f -o cpuTrainerSim
	out=$$(./obj_dir/cpuTrainerSim +verilator+error+limit+100); echo "$$out"; echo "$$out" | grep -q "No errors"

clean:
	rm -rf obj_dir

// ==== dv/cpuTrainerTb.sv ====
`timescale 1ns/1ps

module cpuTrainerTb;

    localparam int debounceCycles = 8;
    localparam int blinkBit       = 3;
    localparam int resetCycles    = 16;
    localparam int holdLong       = debounceCycles + 4;
    localparam int holdShort      = debounceCycles - 2;
    localparam int keyCycles      = 3 * debounceCycles + 8;    // longest hold plus release
    localparam int keyPresses     = 30;
    localparam int maxCycles      = 2 * (resetCycles + keyPresses * keyCycles + 200);

    // active low gfedcba glyphs, F down to 0
    localparam logic [15:0][6:0] glyph = {
        7'h0E, 7'h06, 7'h21, 7'h46, 7'h03, 7'h08, 7'h10, 7'h00,
        7'h78, 7'h02, 7'h12, 7'h19, 7'h30, 7'h24, 7'h79, 7'h40
    };

    logic       clk18;
    logic       rstN;
    logic [3:0] keys;
    logic [9:0] sw;
    logic [6:0] hex0;
    logic [6:0] hex1;
    logic [6:0] hex2;
    logic [6:0] hex3;
    logic [7:0] ledg;
    logic [9:0] ledr;

    int         cycleCount = 0;
    int         darkCnt = 0;
    int         litCnt = 0;
    logic [7:0] rnd [4];
    logic [7:0] prog [8];
    logic [7:0] opA;
    logic [7:0] opB;
    logic [7:0] expAcc;
    logic [7:0] expOut;
    logic [7:0] expMem12;

    trainerClockGen uClockGen (
        .clk (clk18)
    );

    cpuTrainerTop #(
        .debounceCycles (debounceCycles),
        .blinkBit       (blinkBit)
    ) u_dut (
        .clk18 (clk18),
        .rstN  (rstN),
        .keys  (keys),
        .sw    (sw),
        .hex0  (hex0),
        .hex1  (hex1),
        .hex2  (hex2),
        .hex3  (hex3),
        .ledg  (ledg),
        .ledr  (ledr)
    );

    bind cpuTrainerTop cpuTrainerChecker uChecker (
        .clk18    (clk18),
        .rstN     (rstN),
        .keys     (keys),
        .sw       (sw),
        .keyPress (keyPress),
        .start    (start),
        .halted   (halted),
        .state    (state),
        .cpuWe    (cpuBus.we),
        .ledg     (ledg),
        .ledr     (ledr)
    );

    task automatic failRun(input string why);
        $display("Errors found");
        $fatal(1, "%s", why);
    endtask

    task automatic tick(input int n);
        repeat (n) @(posedge clk18);
    endtask

    task automatic expectEq(input string name, input logic [9:0] got, input logic [9:0] exp);
        assert (got == exp)
        else
        begin
            $display("Mismatch %s expected 0x%0h got 0x%0h", name, exp, got);
            failRun("value check failed");
        end
    endtask

    task automatic compareDigits(input logic [7:0] hi, input logic [7:0] lo);
        expectEq("hex3", {3'b000, hex3}, {3'b000, glyph[hi[7:4]]});
        expectEq("hex2", {3'b000, hex2}, {3'b000, glyph[hi[3:0]]});
        expectEq("hex1", {3'b000, hex1}, {3'b000, glyph[lo[7:4]]});
        expectEq("hex0", {3'b000, hex0}, {3'b000, glyph[lo[3:0]]});
    endtask

    task automatic checkDigits(input logic [7:0] hi, input logic [7:0] lo);
        @(negedge clk18);               // outputs settled mid cycle
        compareDigits(hi, lo);
    endtask

    task automatic setSw(input logic [7:0] b, input logic showAddr, input logic edit);
        @(posedge clk18);
        sw <= {b, showAddr, edit};
    endtask

    task automatic pressKey(input int idx, input int holdLen);
        @(posedge clk18);
        keys[idx] <= 1'b0;              // keys are active low
        tick(holdLen);
        keys[idx] <= 1'b1;
        tick(6);
    endtask

    task automatic writeByte(input logic [7:0] b);
        setSw(b, 1'b0, 1'b1);
        pressKey(0, holdLong);          // write, then pointer steps
    endtask

    always @(posedge clk18)
    begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= maxCycles)
        begin
            failRun("timeout, the run did not finish in time");
        end
    end

    always @(negedge clk18)
    begin
        if (u_dut.uChecker.errCount != 0)
        begin
            failRun("a concurrent assertion failed");
        end
    end

    initial
    begin
        void'($urandom(32'h01f5_2d28));
        rstN = 1'b0;
        keys = 4'hF;
        sw   = 10'h003;                 // edit mode, address on the left
        tick(resetCycles);
        rstN <= 1'b1;
        tick(2);

        // debounce seen through the edit pointer
        checkDigits(8'h00, 8'h00);
        pressKey(1, holdShort);
        checkDigits(8'h00, 8'h00);
        pressKey(1, 3 * debounceCycles);
        checkDigits(8'h01, 8'h00);
        pressKey(1, holdLong);
        checkDigits(8'h02, 8'h00);
        pressKey(2, holdLong);
        pressKey(2, holdLong);
        checkDigits(8'h00, 8'h00);

        // random bytes at 0..3, then read back stepping down
        for (int i = 0; i < 4; i++)
        begin
            rnd[i] = 8'($urandom);
            writeByte(rnd[i]);
            checkDigits(8'h00, rnd[i]); // next word still clear
        end
        for (int i = 3; i >= 0; i--)
        begin
            pressKey(2, holdLong);
            checkDigits(rnd[i], rnd[3]);
        end
        pressKey(2, holdLong);
        setSw(rnd[3], 1'b1, 1'b1);
        checkDigits(8'h1F, rnd[3]);     // wrapped below 0

        prog[0] = {cpuTrainerPkg::LDA, 5'd10};
        prog[1] = {cpuTrainerPkg::ADD, 5'd11};
        prog[2] = {cpuTrainerPkg::STA, 5'd12};
        prog[3] = {cpuTrainerPkg::OUT, 5'd0};
        prog[4] = {cpuTrainerPkg::SUB, 5'd11};
        prog[5] = {cpuTrainerPkg::JZ, 5'd7};
        prog[6] = {cpuTrainerPkg::JMP, 5'd1};
        prog[7] = {cpuTrainerPkg::HLT, 5'd0};
        opA = 8'h00;                    // loop ends only when SUB gives zero
        opB = 8'($urandom) | 8'h01;

        pressKey(1, holdLong);          // 31 wraps to 0
        for (int i = 0; i < 8; i++)
        begin
            writeByte(prog[i]);
        end
        pressKey(1, holdLong);
        pressKey(1, holdLong);
        writeByte(opA);
        writeByte(opB);                 // pointer now rests at 12

        // hand trace of the program
        expAcc   = opA;
        expAcc   = expAcc + opB;
        expMem12 = expAcc;
        expOut   = expAcc;
        expAcc   = expAcc - opB;

        setSw(8'h00, 1'b0, 1'b0);
        pressKey(3, holdLong);
        while (ledr[0] !== 1'b1)
        begin
            @(posedge clk18);
        end
        @(negedge clk18);
        expectEq("ledr", ledr, {expOut, 2'b01});
        expectEq("ledg", {2'b00, ledg}, {2'b00, expAcc});
        compareDigits(expOut, expAcc);

        // halted digits alternate between the result and dark
        for (int i = 0; i < (4 << blinkBit); i++)
        begin
            @(negedge clk18);
            if ({hex3, hex2, hex1, hex0} == {4{7'h7F}})
            begin
                darkCnt++;
            end
            else
            begin
                litCnt++;
                compareDigits(expOut, expAcc);
            end
        end
        assert (darkCnt > 0 && litCnt > 0)
        else
        begin
            failRun("the display did not blink while halted");
        end

        setSw(8'h5A, 1'b0, 1'b1);
        tick(2);
        checkDigits(expMem12, 8'h5A);   // word stored by STA

        tick(4);
        if (u_dut.uChecker.errCount != 0)
        begin
            failRun("concurrent assertions failed");
        end
        else
        begin
            $display("No errors");
            $finish;
        end
    end

endmodule

// ==== dv/cpuTrainer_checker.sv ====
`timescale 1ns/1ps

module cpuTrainerChecker (
    input logic                         clk18,
    input logic                         rstN,
    input logic [3:0]                   keys,
    input logic [9:0]                   sw,
    input logic [3:0]                   keyPress,
    input logic                         start,
    input logic                         halted,
    input cpuTrainerPkg::trainerState_t state,
    input logic                         cpuWe,
    input logic [7:0]                   ledg,
    input logic [9:0]                   ledr
);

    int errCount = 0;       // read by the testbench top

    pulseOnce: assert property (@(posedge clk18) disable iff (!rstN)
        (keyPress & $past(keys) & 4'h0) == 4'h0 && (keyPress & $past(keyPress)) == 4'h0)
    else
    begin
        errCount++;
        $error("keyPress stayed high for more than one cycle");
    end

    // a pulse needs the key to have been held down for a while
    pulseNeedsHold: assert property (@(posedge clk18) disable iff (!rstN)
        (keyPress & $past(keys, 3)) == 4'h0)
    else
    begin
        errCount++;
        $error("keyPress pulsed for a key that was not held");
    end

    keyStartsRun: assert property (@(posedge clk18) disable iff (!rstN)
        (keyPress[3] && !sw[0] && state != cpuTrainerPkg::RUN)
        |=> (start && state == cpuTrainerPkg::RUN))
    else
    begin
        errCount++;
        $error("key 3 did not start the CPU in the run state");
    end

    haltFollows: assert property (@(posedge clk18) disable iff (!rstN)
        (state == cpuTrainerPkg::RUN && $rose(halted) && !sw[0])
        |=> state == cpuTrainerPkg::HALTED)
    else
    begin
        errCount++;
        $error("Mismatch state expected 0x2 got 0x%0h", $sampled(state));
    end

    editReturn: assert property (@(posedge clk18) disable iff (!rstN)
        sw[0] |=> state == cpuTrainerPkg::EDIT)
    else
    begin
        errCount++;
        $error("Mismatch state expected 0x0 got 0x%0h", $sampled(state));
    end

    // CPU stores happen only while running
    cpuWriteInRun: assert property (@(posedge clk18) disable iff (!rstN)
        cpuWe |-> state == cpuTrainerPkg::RUN)
    else
    begin
        errCount++;
        $error("CPU write outside the run state");
    end

    // one cycle after sw[0] is seen high the LEDs echo the board inputs
    ledrEdit: assert property (@(posedge clk18) disable iff (!rstN)
        $past(sw[0]) |-> ledr == sw)
    else
    begin
        errCount++;
        $error("Mismatch ledr expected 0x%0h got 0x%0h", $sampled(sw), $sampled(ledr));
    end

    ledgEdit: assert property (@(posedge clk18) disable iff (!rstN)
        $past(sw[0]) |-> ledg == {4'h0, ~keys})
    else
    begin
        errCount++;
        $error("Mismatch ledg expected 0x%0h got 0x%0h",
            $sampled({4'h0, ~keys}), $sampled(ledg));
    end

endmodule

// ==== dv/trainerClockGen.sv ====
`timescale 1ns/1ps

module trainerClockGen #(
    parameter int halfPeriod = 20       // ns, 40 ns period
) (
    output logic clk
);

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #halfPeriod clk = ~clk;
        end
    end

endmodule

// ==== verilog/cpuTrainerTop.sv ====
`timescale 1ns/1ps

`include "trainer_consts.svh"

module cpuTrainerTop #(
    parameter int debounceCycles = `DEBOUNCE_CYCLES,
    parameter int blinkBit       = `BLINK_BIT
) (
    input  logic       clk18,
    input  logic       rstN,
    input  logic [3:0] keys,
    input  logic [9:0] sw,
    output logic [6:0] hex0,
    output logic [6:0] hex1,
    output logic [6:0] hex2,
    output logic [6:0] hex3,
    output logic [7:0] ledg,
    output logic [9:0] ledr
);

    logic [3:0]                   keyPress;
    logic                         start;
    logic                         halted;
    cpuTrainerPkg::trainerState_t state;
    logic [4:0]                   editPtr;
    logic [7:0]                   acc;
    logic [7:0]                   outReg;

    progBusIf editBus ();
    progBusIf cpuBus ();

    keyDebounce #(.holdCycles(debounceCycles)) uKeyDebounce (
        .clk18    (clk18),
        .rstN     (rstN),
        .keys     (keys),
        .keyPress (keyPress)
    );

    trainerControl uTrainerControl (
        .clk18    (clk18),
        .rstN     (rstN),
        .editMode (sw[0]),
        .swData   (sw[9:2]),
        .keyPress (keyPress),
        .halted   (halted),
        .start    (start),
        .state    (state),
        .editPtr  (editPtr),
        .editBus  (editBus.master)
    );

    progMem uProgMem (
        .clk18   (clk18),
        .rstN    (rstN),
        .editBus (editBus.memory),
        .cpuBus  (cpuBus.memory)
    );

    accCpu uAccCpu (
        .clk18  (clk18),
        .rstN   (rstN),
        .start  (start),
        .cpuBus (cpuBus.master),
        .acc    (acc),
        .outReg (outReg),
        .halted (halted)
    );

    segDisplay #(.blinkBit(blinkBit)) uSegDisplay (
        .clk18    (clk18),
        .rstN     (rstN),
        .state    (state),
        .showAddr (sw[1]),
        .swData   (sw[9:2]),
        .editPtr  (editPtr),
        .memWord  (editBus.rdData),   // word under the edit pointer
        .acc      (acc),
        .outReg   (outReg),
        .hex0     (hex0),
        .hex1     (hex1),
        .hex2     (hex2),
        .hex3     (hex3)
    );

    // switches echo in EDIT, CPU results otherwise
    assign ledr = (state == cpuTrainerPkg::EDIT) ? sw : {outReg, 1'b0, halted};
    assign ledg = (state == cpuTrainerPkg::EDIT) ? {4'b0000, ~keys} : acc;

endmodule

// ==== verilog/segDisplay.sv ====
`timescale 1ns/1ps

`include "trainer_consts.svh"

module segDisplay #(
    parameter int blinkBit = `BLINK_BIT
) (
    input  logic                          clk18,
    input  logic                          rstN,
    input  cpuTrainerPkg::trainerState_t  state,
    input  logic                          showAddr,   // sw[1]
    input  logic [7:0]                    swData,
    input  logic [4:0]                    editPtr,
    input  cpuTrainerPkg::progWord_t      memWord,
    input  logic [7:0]                    acc,
    input  logic [7:0]                    outReg,
    output logic [6:0]                    hex0,
    output logic [6:0]                    hex1,
    output logic [6:0]                    hex2,
    output logic [6:0]                    hex3
);

    logic [blinkBit:0]           blinkCnt;
    logic                        blank;
    cpuTrainerPkg::digitBundle_t digits;

    // active low segments, gfedcba
    function automatic logic [6:0] hexToSeg(input logic [3:0] nib);
        case (nib)
            4'h0: hexToSeg = 7'h40;
            4'h1: hexToSeg = 7'h79;
            4'h2: hexToSeg = 7'h24;
            4'h3: hexToSeg = 7'h30;
            4'h4: hexToSeg = 7'h19;
            4'h5: hexToSeg = 7'h12;
            4'h6: hexToSeg = 7'h02;
            4'h7: hexToSeg = 7'h78;
            4'h8: hexToSeg = 7'h00;
            4'h9: hexToSeg = 7'h10;
            4'hA: hexToSeg = 7'h08;
            4'hB: hexToSeg = 7'h03;
            4'hC: hexToSeg = 7'h46;
            4'hD: hexToSeg = 7'h21;
            4'hE: hexToSeg = 7'h06;
            default: hexToSeg = 7'h0E;
        endcase
    endfunction

    // restarts on entry to HALTED so the first phase is lit
    always_ff @(posedge clk18 or negedge rstN)
    begin
        if (!rstN)
        begin
            blinkCnt <= '0;
        end
        else if (state == cpuTrainerPkg::HALTED)
        begin
            blinkCnt <= blinkCnt + 1'b1;
        end
        else
        begin
            blinkCnt <= '0;
        end
    end

    always_comb
    begin
        if (state == cpuTrainerPkg::EDIT)
        begin
            {digits.d1, digits.d0} = swData;
            {digits.d3, digits.d2} = showAddr ? {3'b000, editPtr} : memWord.data;
        end
        else
        begin
            {digits.d1, digits.d0} = acc;
            {digits.d3, digits.d2} = outReg;
        end
    end

    assign blank = (state == cpuTrainerPkg::HALTED) && blinkCnt[blinkBit];

    assign hex0 = blank ? 7'h7F : hexToSeg(digits.d0);
    assign hex1 = blank ? 7'h7F : hexToSeg(digits.d1);
    assign hex2 = blank ? 7'h7F : hexToSeg(digits.d2);
    assign hex3 = blank ? 7'h7F : hexToSeg(digits.d3);

endmodule

// ==== cpu/accCpu.sv ====
`timescale 1ns/1ps

`include "trainer_consts.svh"

module accCpu (
    input  logic        clk18,
    input  logic        rstN,
    input  logic        start,
    progBusIf.master    cpuBus,
    output logic [7:0]  acc,
    output logic [7:0]  outReg,
    output logic        halted
);

    typedef enum logic [2:0] {
        IDLE,
        FETCH,
        DECODE,
        OPRD,       // wait for the operand byte
        EXEC
    } cpuPhase_t;

    cpuPhase_t                phase;
    logic [`ADDR_W-1:0]       pc;
    cpuTrainerPkg::progWord_t ir;
    cpuTrainerPkg::opcode_t   fetchedOp;

    assign fetchedOp = cpuBus.rdData.instr.op;

    // operand address held from DECODE until the instruction retires
    assign cpuBus.addr   = (phase == OPRD || phase == EXEC) ? ir.instr.addr : pc;
    assign cpuBus.we     = (phase == EXEC) && (ir.instr.op == cpuTrainerPkg::STA);
    assign cpuBus.wrData = cpuTrainerPkg::progWord_t'(acc);

    always_ff @(posedge clk18)
    begin
        if (phase == DECODE)
        begin
            ir <= cpuBus.rdData;
        end
    end

    always_ff @(posedge clk18 or negedge rstN)
    begin
        if (!rstN)
        begin
            phase  <= IDLE;
            pc     <= '0;
            acc    <= 8'h00;
            outReg <= 8'h00;
            halted <= 1'b0;
        end
        else if (start)
        begin
            phase  <= FETCH;
            pc     <= '0;
            acc    <= 8'h00;
            outReg <= 8'h00;
            halted <= 1'b0;
        end
        else
        begin
            case (phase)
                FETCH:  phase <= DECODE;
                DECODE:
                begin
                    pc <= pc + 1'b1;
                    if (fetchedOp == cpuTrainerPkg::LDA || fetchedOp == cpuTrainerPkg::ADD ||
                        fetchedOp == cpuTrainerPkg::SUB)
                    begin
                        phase <= OPRD;
                    end
                    else
                    begin
                        phase <= EXEC;
                    end
                end
                OPRD:   phase <= EXEC;
                EXEC:
                begin
                    phase <= FETCH;
                    case (ir.instr.op)
                        cpuTrainerPkg::LDA: acc <= cpuBus.rdData.data;  // word read as data
                        cpuTrainerPkg::ADD: acc <= acc + cpuBus.rdData.data;
                        cpuTrainerPkg::SUB: acc <= acc - cpuBus.rdData.data;
                        cpuTrainerPkg::OUT: outReg <= acc;
                        cpuTrainerPkg::JMP: pc <= ir.instr.addr;
                        cpuTrainerPkg::JZ:
                        begin
                            if (acc == 8'h00)
                            begin
                                pc <= ir.instr.addr;
                            end
                        end
                        cpuTrainerPkg::HLT:
                        begin
                            halted <= 1'b1;     // held until next start
                            phase  <= IDLE;
                        end
                        default: ;              // STA writes through cpuBus.we
                    endcase
                end
                default: phase <= IDLE;
            endcase
        end
    end

endmodule

// ==== cpu/progMem.sv ====
`timescale 1ns/1ps

`include "trainer_consts.svh"

module progMem (
    input  logic      clk18,
    input  logic      rstN,
    progBusIf.memory  editBus,
    progBusIf.memory  cpuBus
);

    cpuTrainerPkg::progWord_t mem [`MEM_DEPTH];

    // edit and CPU writes never coincide, the CPU only runs outside EDIT
    always_ff @(posedge clk18 or negedge rstN)
    begin
        if (!rstN)
        begin
            for (int i = 0; i < `MEM_DEPTH; i++)
            begin
                mem[i] <= '0;
            end
        end
        else if (cpuBus.we)
        begin
            mem[cpuBus.addr] <= cpuBus.wrData;
        end
        else if (editBus.we)
        begin
            mem[editBus.addr] <= editBus.wrData;
        end
    end

    // read before write on both ports
    always_ff @(posedge clk18)
    begin
        editBus.rdData <= mem[editBus.addr];
        cpuBus.rdData  <= mem[cpuBus.addr];
    end

endmodule

// ==== verilog/trainerControl.sv ====
`timescale 1ns/1ps

module trainerControl (
    input  logic                          clk18,
    input  logic                          rstN,
    input  logic                          editMode,   // sw[0]
    input  logic [7:0]                    swData,
    input  logic [3:0]                    keyPress,
    input  logic                          halted,
    output logic                          start,
    output cpuTrainerPkg::trainerState_t  state,
    output logic [4:0]                    editPtr,
    progBusIf.master                      editBus
);

    logic haltedQ;
    logic editing;

    assign editing = (state == cpuTrainerPkg::EDIT) && editMode;

    // the edit port always reads the word under the pointer
    assign editBus.addr   = editPtr;
    assign editBus.we     = editing && keyPress[0];
    assign editBus.wrData = cpuTrainerPkg::progWord_t'(swData);

    // mode state machine
    always_ff @(posedge clk18 or negedge rstN)
    begin
        if (!rstN)
        begin
            state   <= cpuTrainerPkg::EDIT;
            start   <= 1'b0;
            haltedQ <= 1'b0;
        end
        else
        begin
            haltedQ <= halted;
            start   <= 1'b0;
            if (editMode)
            begin
                state <= cpuTrainerPkg::EDIT;       // sw[0] wins from anywhere
            end
            else if (keyPress[3] && state != cpuTrainerPkg::RUN)
            begin
                start <= 1'b1;                      // run from address 0
                state <= cpuTrainerPkg::RUN;
            end
            else if (state == cpuTrainerPkg::RUN && halted && !haltedQ)
            begin
                state <= cpuTrainerPkg::HALTED;
            end
        end
    end

    // edit pointer, wraps modulo 32
    always_ff @(posedge clk18 or negedge rstN)
    begin
        if (!rstN)
        begin
            editPtr <= 5'd0;
        end
        else if (editing)
        begin
            if (keyPress[0] || keyPress[1])
            begin
                editPtr <= editPtr + 5'd1;          // after a write or forward
            end
            else if (keyPress[2])
            begin
                editPtr <= editPtr - 5'd1;
            end
        end
    end

endmodule

// ==== verilog/keyDebounce.sv ====
`timescale 1ns/1ps

`include "trainer_consts.svh"

module keyDebounce #(
    parameter int holdCycles = `DEBOUNCE_CYCLES
) (
    input  logic       clk18,
    input  logic       rstN,
    input  logic [3:0] keys,        // active low push buttons
    output logic [3:0] keyPress     // one pulse per accepted press
);

    localparam int cntW = $clog2(holdCycles + 1);

    localparam logic [cntW-1:0] cntMax  = cntW'(holdCycles);
    localparam logic [cntW-1:0] cntLast = cntW'(holdCycles - 1);

    logic [3:0]      keySync1;
    logic [3:0]      keySync2;
    logic [cntW-1:0] holdCnt [4];

    always_ff @(posedge clk18 or negedge rstN)
    begin
        if (!rstN)
        begin
            keySync1 <= 4'hF;               // buttons idle high
            keySync2 <= 4'hF;
            keyPress <= 4'h0;
            for (int i = 0; i < 4; i++)
            begin
                holdCnt[i] <= '0;
            end
        end
        else
        begin
            keySync1 <= keys;               // board pins are asynchronous
            keySync2 <= keySync1;
            for (int i = 0; i < 4; i++)
            begin
                if (keySync2[i])
                begin
                    holdCnt[i]  <= '0;      // released, rearm
                    keyPress[i] <= 1'b0;
                end
                else if (holdCnt[i] != cntMax)
                begin
                    holdCnt[i]  <= holdCnt[i] + 1'b1;
                    keyPress[i] <= (holdCnt[i] == cntLast);
                end
                else
                begin
                    keyPress[i] <= 1'b0;    // saturated until release
                end
            end
        end
    end

endmodule

// ==== common/progBusIf.sv ====
`timescale 1ns/1ps

`include "trainer_consts.svh"

// one port of the program RAM
// rdData returns the word at the address sampled on the previous edge
interface progBusIf;

    logic [`ADDR_W-1:0]      addr;
    logic                    we;
    cpuTrainerPkg::progWord_t wrData;
    cpuTrainerPkg::progWord_t rdData;

    modport master (
        output addr,
        output we,
        output wrData,
        input  rdData
    );

    modport memory (
        input  addr,
        input  we,
        input  wrData,
        output rdData
    );

endinterface

// ==== common/cpuTrainerPkg.sv ====
package cpuTrainerPkg;

`include "trainer_consts.svh"

    // 3-bit instruction set of the accumulator CPU
    typedef enum logic [2:0] {
        LDA = 3'd0,     // acc = mem[a]
        ADD = 3'd1,     // acc = acc + mem[a]
        SUB = 3'd2,     // acc = acc - mem[a]
        STA = 3'd3,     // mem[a] = acc
        OUT = 3'd4,     // outReg = acc
        JMP = 3'd5,     // pc = a
        JZ  = 3'd6,     // pc = a when acc is zero
        HLT = 3'd7      // stop
    } opcode_t;

    typedef struct packed {
        opcode_t               op;
        logic [`ADDR_W-1:0]    addr;
    } instrFields_t;

    // one memory byte, seen as an instruction or as an operand
    typedef union packed {
        instrFields_t instr;
        logic [7:0]   data;
    } progWord_t;

    typedef enum logic [1:0] {
        EDIT   = 2'd0,
        RUN    = 2'd1,
        HALTED = 2'd2
    } trainerState_t;

    typedef struct packed {
        logic [3:0] d3;     // leftmost digit
        logic [3:0] d2;
        logic [3:0] d1;
        logic [3:0] d0;
    } digitBundle_t;

endpackage

// ==== common/trainer_consts.svh ====
`ifndef TRAINER_CONSTS_SVH
`define TRAINER_CONSTS_SVH

// key must stay low this many clk18 cycles before it counts as a press
// 10800 cycles at 18 MHz is roughly 0.6 ms of stable contact
`define DEBOUNCE_CYCLES 10800

// program memory geometry
`define MEM_DEPTH 32
`define ADDR_W 5

// blink counter bit that gates the digits while halted
// bit 22 at 18 MHz gives a blink period of about half a second
`define BLINK_BIT 22

`endif
